// File: Bender.yml
package:
  name: turf_regbridge

sources:
  - common/turf_reg_pkg.sv
  - common/turf_link_pkg.sv
  - crate_bridge/cmd_framer.sv
  - crate_bridge/crate_bridge.sv
  - source/reg_intercon.sv
  - source/id_ctrl.sv
  - source/turf_regbridge_top.sv
  - target: test
    files:
      - test/turf_regbridge_assertions.sv
      - test/turf_regbridge_tb.sv

// File: common/turf_link_pkg.sv
//////////////////////////////////////////////////////////////////////
// TURFIO link streams and register bridge definitions
//////////////////////////////////////////////////////////////////////
package turf_link_pkg;

    localparam int NUM_LINKS = 4;

    // Link number, carried on tdest
    typedef logic [1:0] link_idx_t;
    typedef logic [NUM_LINKS-1:0] link_mask_t;
    // Register address inside one link
    typedef logic [12:0] link_addr_t;

    // Link number sits just above the link address
    localparam int LINK_IDX_LSB = 13;

    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_e;

    // One bridge_type_e field per link, link 0 in the low bits
    typedef logic [2*NUM_LINKS-1:0] bridge_types_t;

    // Bit 31 write flag, bits 12:0 link address
    typedef logic [31:0] cmd_word_t;

    localparam int BRIDGE_TIMEOUT_CYCLES = 64;
    localparam logic [31:0] BAD_READ_WORD = 32'hFFFFFFFF;

endpackage

// File: common/turf_reg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Register bus widths, address map and identity words
//////////////////////////////////////////////////////////////////////
package turf_reg_pkg;

    // Word address and data on the register bus
    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Set in the address for crate space, clear for ID/control space
    localparam int CRATE_SPACE_BIT = 15;

    // ID/control space word addresses
    localparam reg_addr_t ID_ADDR_IDENT       = 16'd0;
    localparam reg_addr_t ID_ADDR_DATEVER     = 16'd1;
    localparam reg_addr_t ID_ADDR_BRIDGE_TYPE = 16'd2;
    localparam reg_addr_t ID_ADDR_ERR_STATUS  = 16'd3;

    // ASCII "TURF"
    localparam reg_data_t IDENT_WORD = 32'h54555246;

    // Major, minor, revision
    localparam logic [15:0] FW_VERSION = {4'd0, 4'd6, 8'd10};
    localparam logic [14:0] FW_DATE    = 15'h0A5C;
    localparam logic        FW_REV_B   = 1'b1;
    localparam reg_data_t DATEVERSION_WORD = {FW_REV_B, FW_DATE, FW_VERSION};

    // Cycles from sampled request to ack in ID space
    localparam int ID_ACK_CYCLES = 2;

endpackage

// File: crate_bridge/cmd_framer.sv
`timescale 1ns/1ps
module cmd_framer (
    input  logic                       ps_clk,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  logic                       we_i,
    input  turf_link_pkg::link_idx_t   link_i,
    input  turf_link_pkg::link_addr_t  addr_i,
    input  turf_reg_pkg::reg_data_t    wdata_i,
    output logic                       done_o,
    output logic                       cmd_valid_o,
    input  logic                       cmd_ready_i,
    output turf_reg_pkg::reg_data_t    cmd_data_o,
    output turf_link_pkg::link_idx_t   cmd_dest_o,
    output logic                       cmd_last_o
);

    turf_link_pkg::cmd_word_t cmd_word;
    turf_reg_pkg::reg_data_t  data_word;
    // Writes carry a data word after the command
    logic                     two_words;
    // Second word on the bus
    logic                     phase;
    logic                     xfer;

    assign xfer = cmd_valid_o && cmd_ready_i;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            cmd_valid_o <= 1'b0;
            phase       <= 1'b0;
        end else if (start_i) begin
            cmd_valid_o <= 1'b1;
            phase       <= 1'b0;
        end else if (xfer) begin
            if (cmd_last_o) begin
                cmd_valid_o <= 1'b0;
            end else begin
                phase <= 1'b1;
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (start_i) begin
            // Write flag on top, link address in the low bits
            cmd_word   <= {we_i, 18'd0, addr_i};
            data_word  <= wdata_i;
            two_words  <= we_i;
            cmd_dest_o <= link_i;
        end
    end

    assign cmd_data_o = phase ? data_word : cmd_word;
    assign cmd_last_o = phase || !two_words;
    assign done_o     = xfer && cmd_last_o;

endmodule

// File: crate_bridge/crate_bridge.sv
`timescale 1ns/1ps
module crate_bridge (
    input  logic                         ps_clk,
    input  logic                         reset_i,
    input  logic                         start_i,
    input  logic                         we_i,
    input  turf_reg_pkg::reg_addr_t      addr_i,
    input  turf_reg_pkg::reg_data_t      wdata_i,
    output logic                         done_o,
    output turf_reg_pkg::reg_data_t      rdata_o,
    input  turf_link_pkg::bridge_types_t bridge_types_i,
    input  turf_link_pkg::link_mask_t    link_up_i,
    output turf_link_pkg::link_mask_t    timeout_o,
    output turf_link_pkg::link_mask_t    invalid_o,
    output logic                         cmd_valid_o,
    input  logic                         cmd_ready_i,
    output turf_reg_pkg::reg_data_t      cmd_data_o,
    output turf_link_pkg::link_idx_t     cmd_dest_o,
    output logic                         cmd_last_o,
    input  logic                         resp_valid_i,
    output logic                         resp_ready_o,
    input  turf_reg_pkg::reg_data_t      resp_data_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT,
        ST_REPLY
    } state_t;

    state_t                      state;
    turf_link_pkg::link_idx_t    link;
    turf_link_pkg::link_idx_t    link_q;
    turf_link_pkg::bridge_type_e link_type;
    logic                        access_ok;
    logic                        framer_start;
    logic                        framer_done;
    logic [$clog2(turf_link_pkg::BRIDGE_TIMEOUT_CYCLES)-1:0] timer;

    //////////////////////////////////////////////////////////////////////
    // Access check
    //////////////////////////////////////////////////////////////////////

    assign link = turf_link_pkg::link_idx_t'(addr_i >> turf_link_pkg::LINK_IDX_LSB);
    assign link_type = turf_link_pkg::bridge_type_e'(
        bridge_types_i[link*$bits(turf_link_pkg::bridge_type_e) +:
                       $bits(turf_link_pkg::bridge_type_e)]);
    // Only Aurora links that are up take commands
    assign access_ok = (link_type == turf_link_pkg::BRIDGE_AURORA) && link_up_i[link];

    assign framer_start = (state == ST_IDLE) && start_i && access_ok;

    //////////////////////////////////////////////////////////////////////
    // Bridge FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            state     <= ST_IDLE;
            timer     <= '0;
            timeout_o <= '0;
            invalid_o <= '0;
        end else begin
            timeout_o <= '0;
            invalid_o <= '0;
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        if (access_ok) begin
                            state <= ST_SEND;
                        end else begin
                            invalid_o <= turf_link_pkg::link_mask_t'(1) << link;
                            state     <= ST_REPLY;
                        end
                    end
                end
                ST_SEND: begin
                    // Timeout starts at the last command word
                    timer <= '0;
                    if (framer_done) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (resp_valid_i) begin
                        state <= ST_REPLY;
                    end else if (timer == turf_link_pkg::BRIDGE_TIMEOUT_CYCLES - 1) begin
                        timeout_o <= turf_link_pkg::link_mask_t'(1) << link_q;
                        state     <= ST_REPLY;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Reply word and latched link
    always_ff @(posedge ps_clk) begin
        if (state == ST_IDLE && start_i) begin
            link_q  <= link;
            rdata_o <= turf_link_pkg::BAD_READ_WORD;
        end else if (state == ST_WAIT && resp_valid_i) begin
            rdata_o <= resp_data_i;
        end
    end

    assign done_o       = (state == ST_REPLY);
    assign resp_ready_o = (state == ST_WAIT);

    cmd_framer cmd_framer_inst (
        .ps_clk      (ps_clk),
        .reset_i     (reset_i),
        .start_i     (framer_start),
        .we_i        (we_i),
        .link_i      (link),
        .addr_i      (turf_link_pkg::link_addr_t'(addr_i)),
        .wdata_i     (wdata_i),
        .done_o      (framer_done),
        .cmd_valid_o (cmd_valid_o),
        .cmd_ready_i (cmd_ready_i),
        .cmd_data_o  (cmd_data_o),
        .cmd_dest_o  (cmd_dest_o),
        .cmd_last_o  (cmd_last_o)
    );

endmodule

// File: source/id_ctrl.sv
`timescale 1ns/1ps
module id_ctrl (
    input  logic                         ps_clk,
    input  logic                         reset_i,
    input  logic                         start_i,
    input  logic                         we_i,
    input  turf_reg_pkg::reg_addr_t      addr_i,
    input  turf_reg_pkg::reg_data_t      wdata_i,
    output logic                         done_o,
    output turf_reg_pkg::reg_data_t      rdata_o,
    output turf_link_pkg::bridge_types_t bridge_types_o,
    input  turf_link_pkg::link_mask_t    timeout_i,
    input  turf_link_pkg::link_mask_t    invalid_i
);

    turf_link_pkg::bridge_types_t bridge_types;
    turf_link_pkg::link_mask_t    err_timeout;
    turf_link_pkg::link_mask_t    err_invalid;
    turf_link_pkg::link_mask_t    clr_timeout;
    turf_link_pkg::link_mask_t    clr_invalid;
    turf_reg_pkg::reg_data_t      read_word;
    logic                         wr_bridge;
    logic                         wr_err;

    assign wr_bridge = start_i && we_i && (addr_i == turf_reg_pkg::ID_ADDR_BRIDGE_TYPE);
    assign wr_err    = start_i && we_i && (addr_i == turf_reg_pkg::ID_ADDR_ERR_STATUS);

    // Write 1 to clear, timeouts low nibble and invalids above
    assign clr_timeout = wr_err ? wdata_i[turf_link_pkg::NUM_LINKS-1:0] : '0;
    assign clr_invalid = wr_err ?
                         wdata_i[2*turf_link_pkg::NUM_LINKS-1:turf_link_pkg::NUM_LINKS] : '0;

    always_comb begin
        case (addr_i)
            turf_reg_pkg::ID_ADDR_IDENT:       read_word = turf_reg_pkg::IDENT_WORD;
            turf_reg_pkg::ID_ADDR_DATEVER:     read_word = turf_reg_pkg::DATEVERSION_WORD;
            turf_reg_pkg::ID_ADDR_BRIDGE_TYPE: read_word = turf_reg_pkg::reg_data_t'(bridge_types);
            turf_reg_pkg::ID_ADDR_ERR_STATUS:  begin
                read_word = turf_reg_pkg::reg_data_t'({err_invalid, err_timeout});
            end
            default:                           read_word = '0;
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            done_o       <= 1'b0;
            bridge_types <= {turf_link_pkg::NUM_LINKS{turf_link_pkg::BRIDGE_NONE}};
            err_timeout  <= '0;
            err_invalid  <= '0;
        end else begin
            done_o <= start_i;
            if (wr_bridge) begin
                bridge_types <= wdata_i[$bits(turf_link_pkg::bridge_types_t)-1:0];
            end
            // A new error in the clearing cycle stays set
            err_timeout <= (err_timeout & ~clr_timeout) | timeout_i;
            err_invalid <= (err_invalid & ~clr_invalid) | invalid_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (start_i) begin
            rdata_o <= read_word;
        end
    end

    assign bridge_types_o = bridge_types;

endmodule

// File: source/reg_intercon.sv
`timescale 1ns/1ps
module reg_intercon (
    input  logic                    ps_clk,
    input  logic                    reset_i,
    input  logic                    req_valid_i,
    input  logic                    req_we_i,
    input  turf_reg_pkg::reg_addr_t req_addr_i,
    input  turf_reg_pkg::reg_data_t req_wdata_i,
    output logic                    ack_o,
    output turf_reg_pkg::reg_data_t rdata_o,
    output logic                    id_start_o,
    output logic                    crate_start_o,
    output logic                    acc_we_o,
    output turf_reg_pkg::reg_addr_t acc_addr_o,
    output turf_reg_pkg::reg_data_t acc_wdata_o,
    input  logic                    id_done_i,
    input  logic                    crate_done_i,
    input  turf_reg_pkg::reg_data_t id_rdata_i,
    input  turf_reg_pkg::reg_data_t crate_rdata_i
);

    // Access accepted, held until the master drops its request
    logic busy;
    // Waiting on the selected block's done
    logic pending;
    logic sel_crate;
    logic accept;

    assign accept = req_valid_i && !busy;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            busy          <= 1'b0;
            pending       <= 1'b0;
            id_start_o    <= 1'b0;
            crate_start_o <= 1'b0;
        end else begin
            id_start_o    <= 1'b0;
            crate_start_o <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                pending <= 1'b1;
                if (req_addr_i[turf_reg_pkg::CRATE_SPACE_BIT]) begin
                    crate_start_o <= 1'b1;
                end else begin
                    id_start_o <= 1'b1;
                end
            end else if (ack_o) begin
                pending <= 1'b0;
            end else if (!req_valid_i && !pending) begin
                busy <= 1'b0;
            end
        end
    end

    // Access payload, held for the whole transaction
    always_ff @(posedge ps_clk) begin
        if (accept) begin
            sel_crate   <= req_addr_i[turf_reg_pkg::CRATE_SPACE_BIT];
            acc_we_o    <= req_we_i;
            acc_addr_o  <= req_addr_i;
            acc_wdata_o <= req_wdata_i;
        end
    end

    assign ack_o   = pending && (sel_crate ? crate_done_i : id_done_i);
    assign rdata_o = sel_crate ? crate_rdata_i : id_rdata_i;

endmodule

// File: source/turf_regbridge_top.sv
`timescale 1ns/1ps
module turf_regbridge_top (
    input  logic                      ps_clk,
    input  logic                      reset_i,
    // Register bus from the processing system
    input  logic                      req_valid_i,
    input  logic                      req_we_i,
    input  turf_reg_pkg::reg_addr_t   req_addr_i,
    input  turf_reg_pkg::reg_data_t   req_wdata_i,
    output logic                      ack_o,
    output turf_reg_pkg::reg_data_t   rdata_o,
    // Link status
    input  turf_link_pkg::link_mask_t link_up_i,
    // Command stream toward the links
    output logic                      cmd_valid_o,
    input  logic                      cmd_ready_i,
    output turf_reg_pkg::reg_data_t   cmd_data_o,
    output turf_link_pkg::link_idx_t  cmd_dest_o,
    output logic                      cmd_last_o,
    // Response stream from the links
    input  logic                      resp_valid_i,
    output logic                      resp_ready_o,
    input  turf_reg_pkg::reg_data_t   resp_data_i
);

    logic                         id_start;
    logic                         crate_start;
    logic                         acc_we;
    turf_reg_pkg::reg_addr_t      acc_addr;
    turf_reg_pkg::reg_data_t      acc_wdata;
    logic                         id_done;
    logic                         crate_done;
    turf_reg_pkg::reg_data_t      id_rdata;
    turf_reg_pkg::reg_data_t      crate_rdata;
    turf_link_pkg::bridge_types_t bridge_types;
    turf_link_pkg::link_mask_t    bridge_timeout;
    turf_link_pkg::link_mask_t    bridge_invalid;

    reg_intercon reg_intercon_inst (
        .ps_clk        (ps_clk),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_we_i      (req_we_i),
        .req_addr_i    (req_addr_i),
        .req_wdata_i   (req_wdata_i),
        .ack_o         (ack_o),
        .rdata_o       (rdata_o),
        .id_start_o    (id_start),
        .crate_start_o (crate_start),
        .acc_we_o      (acc_we),
        .acc_addr_o    (acc_addr),
        .acc_wdata_o   (acc_wdata),
        .id_done_i     (id_done),
        .crate_done_i  (crate_done),
        .id_rdata_i    (id_rdata),
        .crate_rdata_i (crate_rdata)
    );

    id_ctrl id_ctrl_inst (
        .ps_clk         (ps_clk),
        .reset_i        (reset_i),
        .start_i        (id_start),
        .we_i           (acc_we),
        .addr_i         (acc_addr),
        .wdata_i        (acc_wdata),
        .done_o         (id_done),
        .rdata_o        (id_rdata),
        .bridge_types_o (bridge_types),
        .timeout_i      (bridge_timeout),
        .invalid_i      (bridge_invalid)
    );

    crate_bridge crate_bridge_inst (
        .ps_clk         (ps_clk),
        .reset_i        (reset_i),
        .start_i        (crate_start),
        .we_i           (acc_we),
        .addr_i         (acc_addr),
        .wdata_i        (acc_wdata),
        .done_o         (crate_done),
        .rdata_o        (crate_rdata),
        .bridge_types_i (bridge_types),
        .link_up_i      (link_up_i),
        .timeout_o      (bridge_timeout),
        .invalid_o      (bridge_invalid),
        .cmd_valid_o    (cmd_valid_o),
        .cmd_ready_i    (cmd_ready_i),
        .cmd_data_o     (cmd_data_o),
        .cmd_dest_o     (cmd_dest_o),
        .cmd_last_o     (cmd_last_o),
        .resp_valid_i   (resp_valid_i),
        .resp_ready_o   (resp_ready_o),
        .resp_data_i    (resp_data_i)
    );

endmodule

// File: test/turf_regbridge_assertions.sv
`timescale 1ns/1ps
module turf_regbridge_assertions (
    input logic                     ps_clk,
    input logic                     reset_i,
    input logic                     ack_i,
    input logic                     cmd_valid_i,
    input logic                     cmd_ready_i,
    input turf_reg_pkg::reg_data_t  cmd_data_i,
    input turf_link_pkg::link_idx_t cmd_dest_i,
    input logic                     cmd_last_i,
    input logic                     resp_ready_i
);

    int fail_count = 0;

    // Word on the command stream holds until the link takes it
    cmd_hold: assert property (@(posedge ps_clk) disable iff (reset_i)
        cmd_valid_i && !cmd_ready_i |=>
            cmd_valid_i && $stable({cmd_data_i, cmd_dest_i, cmd_last_i}))
        else begin
            $error("command word changed while the link stalled");
            fail_count++;
        end

    // Single cycle ack
    ack_pulse: assert property (@(posedge ps_clk) disable iff (reset_i)
        ack_i |=> !ack_i)
        else begin
            $error("ack high for two cycles in a row");
            fail_count++;
        end

    // No response accepted while a command is still going out
    resp_after_cmd: assert property (@(posedge ps_clk) disable iff (reset_i)
        cmd_valid_i |-> !resp_ready_i)
        else begin
            $error("response ready while command valid");
            fail_count++;
        end

endmodule

// File: test/turf_regbridge_tb.sv
`timescale 1ns/1ps
module turf_regbridge_tb;

    localparam int          ACK_TIMEOUT = 1000;
    localparam logic [31:0] ALL_ONES    = 32'hFFFFFFFF;

    logic                      ps_clk;
    logic                      reset_i;
    logic                      req_valid_i;
    logic                      req_we_i;
    turf_reg_pkg::reg_addr_t   req_addr_i;
    turf_reg_pkg::reg_data_t   req_wdata_i;
    logic                      ack_o;
    turf_reg_pkg::reg_data_t   rdata_o;
    turf_link_pkg::link_mask_t link_up_i;
    logic                      cmd_valid_o;
    logic                      cmd_ready_i;
    turf_reg_pkg::reg_data_t   cmd_data_o;
    turf_link_pkg::link_idx_t  cmd_dest_o;
    logic                      cmd_last_o;
    logic                      resp_valid_i;
    logic                      resp_ready_o;
    turf_reg_pkg::reg_data_t   resp_data_i;

    // Model of the ID/control registers and the link side
    logic [7:0]                bridge_m;
    logic [3:0]                err_timeout_m;
    logic [3:0]                err_invalid_m;
    logic [3:0]                link_up_m;
    logic                      responder_on;
    logic                      stall_on;
    logic                      stall_pat [0:255];
    logic [7:0]                cyc;
    turf_reg_pkg::reg_data_t   resp_word;
    int                        errors;
    int                        checks;
    logic                      in_flight;
    int                        lat;

    // Expected results with one entry per access
    turf_reg_pkg::reg_data_t   exp_data_q [$];
    logic                      exp_chk_q [$];
    int                        exp_lat_q [$];
    int                        exp_ncmd_q [$];
    // Command beats as {dest, last, data}
    logic [34:0]               exp_cmd_q [$];
    logic [34:0]               got_cmd_q [$];

    turf_regbridge_top turf_regbridge_top_inst (.*);

    bind turf_regbridge_top turf_regbridge_assertions turf_regbridge_assertions_inst (
        .ps_clk       (ps_clk),
        .reset_i      (reset_i),
        .ack_i        (ack_o),
        .cmd_valid_i  (cmd_valid_o),
        .cmd_ready_i  (cmd_ready_i),
        .cmd_data_i   (cmd_data_o),
        .cmd_dest_i   (cmd_dest_o),
        .cmd_last_i   (cmd_last_o),
        .resp_ready_i (resp_ready_o)
    );

    initial ps_clk = 1'b0;
    always #50 ps_clk = ~ps_clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Aurora bridge and link up
    function automatic logic link_valid(input turf_reg_pkg::reg_addr_t addr);
        logic [1:0] link;
        link = addr[14:13];
        return (bridge_m[2*link +: 2] == 2'd1) && link_up_m[link];
    endfunction

    function automatic turf_reg_pkg::reg_data_t expect_rdata(
        input turf_reg_pkg::reg_addr_t addr
    );
        if (addr[15]) begin
            if (!link_valid(addr) || !responder_on) begin
                return ALL_ONES;
            end
            return resp_word;
        end
        case (addr)
            16'd0:   return 32'h54555246;
            16'd1:   return turf_reg_pkg::DATEVERSION_WORD;
            16'd2:   return {24'd0, bridge_m};
            16'd3:   return {24'd0, err_invalid_m, err_timeout_m};
            default: return 32'd0;
        endcase
    endfunction

    function automatic void update_model(input logic we, input turf_reg_pkg::reg_addr_t addr,
                                         input turf_reg_pkg::reg_data_t wdata, input logic ok);
        if (addr[15]) begin
            if (!ok) begin
                err_invalid_m[addr[14:13]] = 1'b1;
            end else if (!responder_on) begin
                err_timeout_m[addr[14:13]] = 1'b1;
            end
        end else if (we && addr == 16'd2) begin
            bridge_m = wdata[7:0];
        end else if (we && addr == 16'd3) begin
            err_timeout_m = err_timeout_m & ~wdata[3:0];
            err_invalid_m = err_invalid_m & ~wdata[7:4];
        end
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic set_link_up(input logic [3:0] mask);
        link_up_i <= mask;
        link_up_m = mask;
        @(posedge ps_clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus master
    //////////////////////////////////////////////////////////////////////

    task automatic bus_access(input logic we, input turf_reg_pkg::reg_addr_t addr,
                              input turf_reg_pkg::reg_data_t wdata, input logic check_data);
        int         cycles;
        logic       ok;
        logic [1:0] link;
        link = addr[14:13];
        ok   = addr[15] && link_valid(addr);
        exp_data_q.push_back(expect_rdata(addr));
        exp_chk_q.push_back(check_data);
        exp_lat_q.push_back(ok ? -1 : 2);
        if (ok) begin
            exp_ncmd_q.push_back(we ? 2 : 1);
            exp_cmd_q.push_back({link, !we, we, 18'd0, addr[12:0]});
            if (we) begin
                exp_cmd_q.push_back({link, 1'b1, wdata});
            end
        end else begin
            exp_ncmd_q.push_back(0);
        end
        req_valid_i <= 1'b1;
        req_we_i    <= we;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        cycles = 0;
        @(posedge ps_clk);
        while (!ack_o && cycles < ACK_TIMEOUT) begin
            cycles++;
            @(posedge ps_clk);
        end
        if (!ack_o) begin
            abort_run($sformatf("no ack for the access to address %h", addr));
        end else begin
            req_valid_i <= 1'b0;
            @(posedge ps_clk);
            update_model(we, addr, wdata, ok);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Link side with random stalls, command capture and the responder
    //////////////////////////////////////////////////////////////////////

    always @(posedge ps_clk) begin
        cyc <= cyc + 1'b1;
        if (reset_i) begin
            cmd_ready_i <= 1'b0;
        end else begin
            cmd_ready_i <= stall_on ? stall_pat[cyc] : 1'b1;
        end
    end

    always @(posedge ps_clk) begin
        if (resp_valid_i && resp_ready_o) begin
            resp_valid_i <= 1'b0;
        end
        if (cmd_valid_o && cmd_ready_i) begin
            got_cmd_q.push_back({cmd_dest_o, cmd_last_o, cmd_data_o});
            if (cmd_last_o && responder_on) begin
                resp_valid_i <= 1'b1;
                resp_data_i  <= resp_word;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare
    //////////////////////////////////////////////////////////////////////

    task automatic check_ack();
        turf_reg_pkg::reg_data_t exp_data;
        logic                    chk;
        int                      exp_lat;
        int                      ncmd;
        int                      k;
        logic [34:0]             beat;
        if (exp_data_q.size() == 0) begin
            errors++;
            $display("Ack arrived with no access pending");
        end else begin
            exp_data = exp_data_q.pop_front();
            chk      = exp_chk_q.pop_front();
            exp_lat  = exp_lat_q.pop_front();
            ncmd     = exp_ncmd_q.pop_front();
            checks++;
            if (chk && rdata_o !== exp_data) begin
                errors++;
                $display("[ERROR] rdata_o: got %h, expected %h (address %h)",
                         rdata_o, exp_data, req_addr_i);
            end
            if (exp_lat >= 0 && lat != exp_lat) begin
                errors++;
                $display("Ack for address %h came %0d cycles after the request, not %0d",
                         req_addr_i, lat, exp_lat);
            end
            if (got_cmd_q.size() != ncmd) begin
                errors++;
                $display("Link got %0d command words for address %h, expected %0d",
                         got_cmd_q.size(), req_addr_i, ncmd);
            end
            for (k = 0; k < ncmd; k++) begin
                beat = exp_cmd_q.pop_front();
                if (k < got_cmd_q.size() && got_cmd_q[k] !== beat) begin
                    errors++;
                    $display("[ERROR] cmd_dest_o/cmd_last_o/cmd_data_o: got %h, expected %h",
                             got_cmd_q[k], beat);
                end
            end
            got_cmd_q.delete();
        end
    endtask

    // Latency counts edges from the one that first samples the request
    always @(posedge ps_clk) begin
        if (!reset_i) begin
            if (req_valid_i && !in_flight) begin
                in_flight = 1'b1;
                lat = 0;
            end else if (in_flight) begin
                lat = lat + 1;
            end
            if (ack_o) begin
                in_flight = 1'b0;
                check_ack();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int                      i;
        turf_reg_pkg::reg_addr_t addr;
        turf_reg_pkg::reg_data_t data;
        void'($urandom(76));
        reset_i      = 1'b1;
        req_valid_i  = 1'b0;
        req_we_i     = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        link_up_i    = '0;
        cmd_ready_i  = 1'b0;
        resp_valid_i = 1'b0;
        resp_data_i  = '0;
        bridge_m      = '0;
        err_timeout_m = '0;
        err_invalid_m = '0;
        link_up_m     = '0;
        responder_on  = 1'b1;
        stall_on      = 1'b0;
        resp_word     = '0;
        cyc           = '0;
        errors        = 0;
        checks        = 0;
        in_flight     = 1'b0;
        lat           = 0;
        for (i = 0; i < 256; i++) begin
            stall_pat[i] = ($urandom % 4) != 0;
        end
        repeat (16) @(posedge ps_clk);
        reset_i <= 1'b0;
        @(posedge ps_clk);

        // Identity, version and reset values and an unmapped word
        for (i = 0; i < 4; i++) begin
            bus_access(1'b0, 16'(i), 32'd0, 1'b1);
        end
        bus_access(1'b0, 16'h0011, 32'd0, 1'b1);

        // All links up but no bridge type set yet
        set_link_up(4'hF);
        bus_access(1'b0, 16'hC044, 32'd0, 1'b1);
        bus_access(1'b0, 16'h0003, 32'd0, 1'b1);

        // Aurora on links 0 to 2 while link 3 stays without a bridge
        data = $urandom;
        data[7:0] = 8'h15;
        bus_access(1'b1, 16'h0002, data, 1'b0);
        bus_access(1'b0, 16'h0002, 32'd0, 1'b1);
        bus_access(1'b1, 16'hE123, $urandom, 1'b1);
        bus_access(1'b1, 16'h0003, 32'h000000FF, 1'b0);
        bus_access(1'b0, 16'h0003, 32'd0, 1'b1);

        // Link 1 down
        set_link_up(4'b1101);
        bus_access(1'b1, 16'hA010, $urandom, 1'b1);
        bus_access(1'b0, 16'h0003, 32'd0, 1'b1);

        // Writes and reads on links 0 and 2 with random stalls
        stall_on = 1'b1;
        for (i = 0; i < 10; i++) begin
            addr = $urandom;
            addr[15] = 1'b1;
            addr[14:13] = ($urandom % 2) ? 2'd2 : 2'd0;
            resp_word = $urandom;
            bus_access((i % 2) == 0, addr, $urandom, 1'b1);
        end
        stall_on = 1'b0;

        // Silent link times out and only its timeout bit is cleared
        responder_on = 1'b0;
        bus_access(1'b0, 16'h8321, 32'd0, 1'b1);
        responder_on = 1'b1;
        bus_access(1'b0, 16'h0003, 32'd0, 1'b1);
        bus_access(1'b1, 16'h0003, 32'h00000001, 1'b0);
        bus_access(1'b0, 16'h0003, 32'd0, 1'b1);

        errors = errors + turf_regbridge_top_inst.turf_regbridge_assertions_inst.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: turf_regbridge.f
common/turf_reg_pkg.sv
common/turf_link_pkg.sv
crate_bridge/cmd_framer.sv
crate_bridge/crate_bridge.sv
source/reg_intercon.sv
source/id_ctrl.sv
source/turf_regbridge_top.sv
test/turf_regbridge_assertions.sv
test/turf_regbridge_tb.sv
